// ==== hw/game_pkg.sv ====
package game_pkg;

    typedef logic [7:0] coord_t;
    typedef logic [2:0] colour_t;
    typedef logic [2:0] score_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    // fleet layout
    localparam int     NUM_ENEMIES   = 5;
    localparam coord_t ENEMY_SPACING = 8'd30;   // x gap between neighbours
    localparam int     ENEMY_W       = 5;
    localparam int     ENEMY_H       = 3;

    // player ship and its bullet
    localparam pos_t   PLAYER_START = '{x: 8'd80, y: 8'd118};
    localparam coord_t PLAYER_STEP  = 8'd3;
    localparam coord_t PLAYER_X_MIN = 8'd9;     // strict, move only if above
    localparam coord_t PLAYER_X_MAX = 8'd151;   // strict, move only if below
    localparam coord_t BULLET_STEP  = 8'd4;
    localparam coord_t BULLET_TOP   = 8'd10;

    // march limits, drop differs per side
    localparam pos_t   FLEET_START      = '{x: 8'd10, y: 8'd10};
    localparam coord_t FLEET_X_LEFT     = 8'd10;
    localparam coord_t FLEET_X_RIGHT    = 8'd30;
    localparam coord_t FLEET_DROP_RIGHT = 8'd2;
    localparam coord_t FLEET_DROP_LEFT  = 8'd1;

    localparam colour_t COL_BLACK  = 3'd0;
    localparam colour_t COL_PLAYER = 3'd3;
    localparam colour_t COL_ENEMY  = 3'd4;
    localparam colour_t COL_BULLET = 3'd7;

    // 60 fps at 50 MHz
    localparam int FRAME_CYCLES_DEFAULT = 833333;

endpackage

// ==== hw/draw_pkg.sv ====
package draw_pkg;

    typedef enum logic [1:0] {
        OP_PLAYER,
        OP_BULLET,
        OP_ENEMY
    } sprite_op_t;

    typedef struct packed {
        sprite_op_t op;
        logic       erase;   // plot in black
        logic [2:0] slot;    // enemy index, ignored otherwise
    } plot_cmd_t;

    typedef struct packed {
        game_pkg::pos_t    pos;
        game_pkg::colour_t colour;
    } pixel_t;

    typedef struct packed {
        logic left;
        logic right;
        logic fire;
        logic run;
    } buttons_t;

    typedef enum logic [3:0] {
        ST_INIT_PLAYER, ST_INIT_ENEMY, ST_WAIT,
        ST_ERASE_PLAYER, ST_ACTION, ST_DRAW_PLAYER,
        ST_ERASE_BULLET, ST_STEP_BULLET, ST_DRAW_BULLET,
        ST_ERASE_ENEMY, ST_STEP_FLEET, ST_DRAW_ENEMY,
        ST_CHECK, ST_DONE
    } ctrl_state_t;

endpackage

// ==== hw/game_ctrl.sv ====
`timescale 1ns/100ps

module game_ctrl #(
    parameter int frame_cycles = game_pkg::FRAME_CYCLES_DEFAULT
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  draw_pkg::buttons_t               buttons,
    input  logic                             bullet_active,
    input  logic [game_pkg::NUM_ENEMIES-1:0] alive,
    input  logic                             game_over,
    input  logic                             plot_done,
    output draw_pkg::plot_cmd_t              cmd,
    output logic                             plot_start,
    output logic                             move_left,
    output logic                             move_right,
    output logic                             fire,
    output logic                             bullet_step,
    output logic                             fleet_step,
    output logic                             hit_check
);
    import game_pkg::*;
    import draw_pkg::*;

    localparam int CNT_W = $clog2(frame_cycles);

    ctrl_state_t      state, next_state;
    logic [CNT_W-1:0] frame_cnt;
    logic             frame_tick;
    logic [2:0]       slot;
    logic             waiting;     // sprite issued and done not yet seen
    logic             is_sprite;
    logic             need;        // low when the sprite is skipped
    logic             sprite_end;
    logic             last_slot;

    // frame timer pauses while run is low
    always_ff @(posedge clk) begin
        if (!resetn) begin
            frame_cnt <= CNT_W'(frame_cycles - 1);
        end else if (buttons.run) begin
            frame_cnt <= frame_tick ? CNT_W'(frame_cycles - 1) : frame_cnt - 1'b1;
        end
    end
    assign frame_tick = buttons.run && (frame_cnt == '0);

    always_comb begin
        is_sprite = 1'b1;
        need      = 1'b1;
        cmd.op    = OP_PLAYER;
        cmd.erase = 1'b0;
        cmd.slot  = slot;
        case (state)
            ST_INIT_PLAYER, ST_DRAW_PLAYER: cmd.op = OP_PLAYER;
            ST_ERASE_PLAYER: cmd.erase = 1'b1;
            ST_ERASE_BULLET: begin
                cmd.op    = OP_BULLET;
                cmd.erase = 1'b1;
            end
            ST_DRAW_BULLET: begin
                cmd.op = OP_BULLET;
                need   = bullet_active;   // may have left the screen on the step
            end
            ST_INIT_ENEMY, ST_DRAW_ENEMY: begin
                cmd.op = OP_ENEMY;
                need   = alive[slot];
            end
            ST_ERASE_ENEMY: begin
                cmd.op    = OP_ENEMY;
                cmd.erase = 1'b1;
                need      = alive[slot];
            end
            default: is_sprite = 1'b0;
        endcase
    end

    assign plot_start = is_sprite && need && !waiting;
    assign sprite_end = is_sprite && (!need || plot_done);
    assign last_slot  = slot == 3'(NUM_ENEMIES - 1);

    always_comb begin
        next_state = state;
        case (state)
            ST_INIT_PLAYER:  if (sprite_end) next_state = ST_INIT_ENEMY;
            ST_INIT_ENEMY:   if (sprite_end && last_slot) next_state = ST_WAIT;
            ST_WAIT: begin
                // game_over settles one cycle after the hit check
                if (game_over) next_state = ST_DONE;
                else if (frame_tick) next_state = ST_ERASE_PLAYER;
            end
            ST_ERASE_PLAYER: if (sprite_end) next_state = ST_ACTION;
            ST_ACTION:       next_state = ST_DRAW_PLAYER;
            ST_DRAW_PLAYER: begin
                if (sprite_end) next_state = bullet_active ? ST_ERASE_BULLET : ST_STEP_BULLET;
            end
            ST_ERASE_BULLET: if (sprite_end) next_state = ST_STEP_BULLET;
            ST_STEP_BULLET:  next_state = ST_DRAW_BULLET;
            ST_DRAW_BULLET:  if (sprite_end) next_state = ST_ERASE_ENEMY;
            ST_ERASE_ENEMY:  if (sprite_end && last_slot) next_state = ST_STEP_FLEET;
            ST_STEP_FLEET:   next_state = ST_DRAW_ENEMY;
            ST_DRAW_ENEMY:   if (sprite_end && last_slot) next_state = ST_CHECK;
            ST_CHECK:        next_state = ST_WAIT;
            default:         next_state = ST_DONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state   <= ST_INIT_PLAYER;
            slot    <= '0;
            waiting <= 1'b0;
        end else begin
            state <= next_state;
            if (plot_start) waiting <= 1'b1;
            else if (plot_done) waiting <= 1'b0;
            if (sprite_end && cmd.op == OP_ENEMY) slot <= last_slot ? '0 : slot + 3'd1;
        end
    end

    // left beats right and right beats fire
    assign move_left   = (state == ST_ACTION) && buttons.left;
    assign move_right  = (state == ST_ACTION) && !buttons.left && buttons.right;
    assign fire        = (state == ST_ACTION) && !buttons.left && !buttons.right && buttons.fire;
    assign bullet_step = state == ST_STEP_BULLET;
    assign fleet_step  = state == ST_STEP_FLEET;
    assign hit_check   = state == ST_CHECK;

    // the plotter only finishes a sprite that was issued and is still open
    assert property (@(posedge clk) disable iff (!resetn)
        plot_done |-> waiting);

endmodule

// ==== hw/sprite_plotter.sv ====
`timescale 1ns/100ps

module sprite_plotter (
    input  logic                clk,
    input  logic                resetn,
    input  draw_pkg::plot_cmd_t cmd,
    input  logic                plot_start,
    input  game_pkg::pos_t      player_pos,
    input  game_pkg::pos_t      bullet_pos,
    input  game_pkg::pos_t      fleet_origin,
    output draw_pkg::pixel_t    pixel,
    output logic                plot,
    output logic                plot_done
);
    import game_pkg::*;
    import draw_pkg::*;

    sprite_op_t op_q;
    logic       erase_q;
    pos_t       base_q;
    logic       busy;
    logic [3:0] step;
    logic [2:0] dx;          // enemy column
    logic [1:0] dy;          // enemy row
    logic [3:0] last_step;
    colour_t    sprite_col;

    always_ff @(posedge clk) begin
        if (plot_start) begin
            case (cmd.op)
                OP_PLAYER: base_q <= player_pos;
                OP_BULLET: base_q <= bullet_pos;
                default: begin
                    base_q.x <= fleet_origin.x + cmd.slot * ENEMY_SPACING;
                    base_q.y <= fleet_origin.y;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            op_q    <= OP_PLAYER;
            erase_q <= 1'b0;
            busy    <= 1'b0;
            step    <= '0;
            dx      <= '0;
            dy      <= '0;
        end else if (plot_start) begin
            op_q    <= cmd.op;
            erase_q <= cmd.erase;
            busy    <= 1'b1;
            step    <= '0;
            dx      <= '0;
            dy      <= '0;
        end else if (busy) begin
            busy <= !plot_done;
            step <= step + 4'd1;
            if (dx == 3'(ENEMY_W - 1)) begin   // row-major walk
                dx <= '0;
                dy <= dy + 2'd1;
            end else begin
                dx <= dx + 3'd1;
            end
        end
    end

    always_comb begin
        pixel.pos  = base_q;
        last_step  = 4'd0;
        sprite_col = COL_BULLET;
        case (op_q)
            OP_PLAYER: begin
                last_step  = 4'd3;
                sprite_col = COL_PLAYER;
                if (step != 4'd0) begin            // bottom row spans x-1 .. x+1
                    pixel.pos.x = base_q.x + coord_t'(step) - 8'd2;
                    pixel.pos.y = base_q.y + 8'd1;
                end
            end
            OP_ENEMY: begin
                last_step   = 4'(ENEMY_W * ENEMY_H - 1);
                sprite_col  = COL_ENEMY;
                pixel.pos.x = base_q.x + coord_t'(dx);
                pixel.pos.y = base_q.y + coord_t'(dy);
            end
            default: ;
        endcase
        pixel.colour = erase_q ? COL_BLACK : sprite_col;
    end

    assign plot      = busy;
    assign plot_done = busy && (step == last_step);

    // done comes on a pixel and the next sprite always leaves a gap
    assert property (@(posedge clk) disable iff (!resetn)
        plot_done |-> plot ##1 !plot);

endmodule

// ==== hw/enemy_fleet.sv ====
`timescale 1ns/100ps

module enemy_fleet (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             fleet_step,
    input  logic                             hit_check,
    input  game_pkg::pos_t                   bullet_pos,
    input  logic                             bullet_active,
    output game_pkg::pos_t                   fleet_origin,
    output logic [game_pkg::NUM_ENEMIES-1:0] alive,
    output logic                             bullet_kill,
    output game_pkg::score_t                 score,
    output logic                             game_over
);
    import game_pkg::*;

    logic                   moving_left;
    logic [NUM_ENEMIES-1:0] hits;
    coord_t                 box_x [NUM_ENEMIES];

    always_comb begin
        for (int k = 0; k < NUM_ENEMIES; k++) begin
            box_x[k] = fleet_origin.x + coord_t'(k) * ENEMY_SPACING;
            hits[k]  = alive[k]
                    && bullet_pos.x >= box_x[k]
                    && bullet_pos.x <= box_x[k] + coord_t'(ENEMY_W - 1)
                    && bullet_pos.y >= fleet_origin.y
                    && bullet_pos.y <= fleet_origin.y + coord_t'(ENEMY_H - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            fleet_origin <= FLEET_START;
            moving_left  <= 1'b0;
            alive        <= '1;
            bullet_kill  <= 1'b0;
        end else begin
            bullet_kill <= 1'b0;
            if (fleet_step) begin
                if (!moving_left && fleet_origin.x == FLEET_X_RIGHT) begin
                    fleet_origin.y <= fleet_origin.y + FLEET_DROP_RIGHT;
                    moving_left    <= 1'b1;
                end else if (moving_left && fleet_origin.x == FLEET_X_LEFT) begin
                    fleet_origin.y <= fleet_origin.y + FLEET_DROP_LEFT;
                    moving_left    <= 1'b0;
                end else begin
                    fleet_origin.x <= moving_left ? fleet_origin.x - 8'd1
                                                  : fleet_origin.x + 8'd1;
                end
            end
            if (hit_check && bullet_active && |hits) begin
                alive       <= alive & ~hits;   // overlapping boxes all die
                bullet_kill <= 1'b1;
            end
        end
    end

    always_comb begin
        score = '0;
        for (int k = 0; k < NUM_ENEMIES; k++) score = score + score_t'(!alive[k]);
    end
    assign game_over = alive == '0;

    assert property (@(posedge clk) disable iff (!resetn) score >= $past(score));

endmodule

// ==== hw/shooter.sv ====
`timescale 1ns/100ps

module shooter (
    input  logic           clk,
    input  logic           resetn,
    input  logic           move_left,
    input  logic           move_right,
    input  logic           fire,
    input  logic           bullet_step,
    input  logic           bullet_kill,
    output game_pkg::pos_t player_pos,
    output game_pkg::pos_t bullet_pos,
    output logic           bullet_active
);
    import game_pkg::*;

    logic launch;

    assign launch = fire && !bullet_active;   // one bullet on screen at most

    always_ff @(posedge clk) begin
        if (!resetn) begin
            player_pos    <= PLAYER_START;
            bullet_active <= 1'b0;
        end else begin
            if (move_left && player_pos.x > PLAYER_X_MIN) begin
                player_pos.x <= player_pos.x - PLAYER_STEP;
            end else if (move_right && player_pos.x < PLAYER_X_MAX) begin
                player_pos.x <= player_pos.x + PLAYER_STEP;
            end
            if (launch) bullet_active <= 1'b1;
            else if (bullet_step && bullet_pos.y <= BULLET_TOP) bullet_active <= 1'b0;
            else if (bullet_kill) bullet_active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            bullet_pos.x <= player_pos.x;
            bullet_pos.y <= player_pos.y - 8'd1;   // just above the ship tip
        end else if (bullet_step && bullet_active && bullet_pos.y > BULLET_TOP) begin
            bullet_pos.y <= bullet_pos.y - BULLET_STEP;
        end
    end

endmodule

// ==== hw/space_invaders_top.sv ====
`timescale 1ns/100ps

module space_invaders_top #(
    parameter int frame_cycles = game_pkg::FRAME_CYCLES_DEFAULT
) (
    input  logic               clk,
    input  logic               resetn,
    input  draw_pkg::buttons_t buttons,
    output draw_pkg::pixel_t   pixel,
    output logic               plot,
    output game_pkg::score_t   score,
    output logic               game_over
);
    import game_pkg::*;
    import draw_pkg::*;

    plot_cmd_t              cmd;
    logic                   plot_start, plot_done;
    logic                   move_left, move_right, fire;
    logic                   bullet_step, fleet_step, hit_check;
    logic                   bullet_active, bullet_kill;
    logic [NUM_ENEMIES-1:0] alive;
    pos_t                   player_pos, bullet_pos, fleet_origin;

    game_ctrl #(.frame_cycles(frame_cycles)) i_ctrl (
        .clk, .resetn, .buttons, .bullet_active, .alive, .game_over, .plot_done,
        .cmd, .plot_start, .move_left, .move_right, .fire,
        .bullet_step, .fleet_step, .hit_check
    );

    sprite_plotter i_plotter (
        .clk, .resetn, .cmd, .plot_start, .player_pos, .bullet_pos, .fleet_origin,
        .pixel, .plot, .plot_done
    );

    shooter i_shooter (
        .clk, .resetn, .move_left, .move_right, .fire, .bullet_step, .bullet_kill,
        .player_pos, .bullet_pos, .bullet_active
    );

    enemy_fleet i_fleet (
        .clk, .resetn, .fleet_step, .hit_check, .bullet_pos, .bullet_active,
        .fleet_origin, .alive, .bullet_kill, .score, .game_over
    );

endmodule

// ==== dv/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
    parameter int half_period = 50
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // low for the first two rising edges
    initial begin
        resetn = 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;
    import game_pkg::*;
    import draw_pkg::*;

    localparam int FRAME_CYCLES    = 400;
    localparam int MAX_HUNT_FRAMES = 800;
    // startup, movement, bullet, march, hunt and the quiet tail
    localparam int PLANNED_FRAMES  = 1 + 75 + 38 + 50 + MAX_HUNT_FRAMES + 2;
    localparam int WATCHDOG_CYCLES = (PLANNED_FRAMES + 4) * FRAME_CYCLES;

    localparam buttons_t BTN_IDLE  = '{left: 1'b0, right: 1'b0, fire: 1'b0, run: 1'b1};
    localparam buttons_t BTN_LEFT  = '{left: 1'b1, right: 1'b0, fire: 1'b0, run: 1'b1};
    localparam buttons_t BTN_RIGHT = '{left: 1'b0, right: 1'b1, fire: 1'b0, run: 1'b1};
    localparam buttons_t BTN_FIRE  = '{left: 1'b0, right: 1'b0, fire: 1'b1, run: 1'b1};

    typedef struct packed {
        coord_t                 px;
        logic                   ba;      // bullet active
        pos_t                   bp;
        pos_t                   fo;      // fleet origin
        logic                   fl;      // marching left
        logic [NUM_ENEMIES-1:0] alive;
    } model_t;

    logic     clk;
    logic     resetn;
    buttons_t buttons;
    pixel_t   pixel;
    logic     plot;
    score_t   score;
    logic     game_over;

    model_t      m;
    pixel_t      exp_q[$];
    logic [31:0] rng_state = 32'h7583;

    tb_clock i_clock (.clk, .resetn);

    space_invaders_top #(.frame_cycles(FRAME_CYCLES)) i_dut (
        .clk, .resetn, .buttons, .pixel, .plot, .score, .game_over
    );

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_pixel(pixel_t got, pixel_t want);
        if (got !== want) begin
            $display("** Error: pixel = %h, expected %h", got, want);
            abort_run();
        end
    endtask

    task automatic check_score(score_t got, score_t want);
        if (got !== want) begin
            $display("** Error: score = %h, expected %h", got, want);
            abort_run();
        end
    endtask

    task automatic check_flag(logic got, logic want, string name);
        if (got !== want) begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic void queue_pixel(coord_t x, coord_t y, colour_t c);
        pixel_t p;
        p.pos.x  = x;
        p.pos.y  = y;
        p.colour = c;
        exp_q.push_back(p);
    endfunction

    function automatic void player_shape(coord_t x, colour_t c);
        queue_pixel(x, 8'd118, c);          // tip, then the row below
        queue_pixel(x - 8'd1, 8'd119, c);
        queue_pixel(x, 8'd119, c);
        queue_pixel(x + 8'd1, 8'd119, c);
    endfunction

    function automatic void enemy_blocks(model_t s, colour_t c);
        for (int k = 0; k < NUM_ENEMIES; k++) begin
            if (s.alive[k]) begin
                for (int dy = 0; dy < 3; dy++) begin
                    for (int dx = 0; dx < 5; dx++) begin
                        queue_pixel(s.fo.x + coord_t'(30 * k + dx), s.fo.y + coord_t'(dy), c);
                    end
                end
            end
        end
    endfunction

    function automatic score_t score_of(model_t s);
        return score_t'(NUM_ENEMIES - $countones(s.alive));
    endfunction

    // one frame of game rules, optionally queueing the pixels it plots
    function automatic void model_frame(inout model_t s, input buttons_t b, input bit emit);
        logic [NUM_ENEMIES-1:0] hit;
        coord_t                 lo;
        if (emit) player_shape(s.px, COL_BLACK);
        if (b.left) begin
            if (s.px > 8'd9) s.px = s.px - 8'd3;
        end else if (b.right) begin
            if (s.px < 8'd151) s.px = s.px + 8'd3;
        end else if (b.fire && !s.ba) begin
            s.ba   = 1'b1;
            s.bp.x = s.px;
            s.bp.y = 8'd117;
        end
        if (emit) player_shape(s.px, COL_PLAYER);
        if (emit && s.ba) queue_pixel(s.bp.x, s.bp.y, COL_BLACK);
        if (s.ba) begin
            if (s.bp.y <= 8'd10) s.ba = 1'b0;
            else s.bp.y = s.bp.y - 8'd4;
        end
        if (emit && s.ba) queue_pixel(s.bp.x, s.bp.y, COL_BULLET);
        if (emit) enemy_blocks(s, COL_BLACK);
        if (!s.fl && s.fo.x == 8'd30) begin          // right edge, drop 2
            s.fo.y = s.fo.y + 8'd2;
            s.fl   = 1'b1;
        end else if (s.fl && s.fo.x == 8'd10) begin
            s.fo.y = s.fo.y + 8'd1;
            s.fl   = 1'b0;
        end else begin
            s.fo.x = s.fl ? s.fo.x - 8'd1 : s.fo.x + 8'd1;
        end
        if (emit) enemy_blocks(s, COL_ENEMY);
        hit = '0;
        for (int k = 0; k < NUM_ENEMIES; k++) begin
            lo     = s.fo.x + coord_t'(30 * k);
            hit[k] = s.ba && s.alive[k] && s.bp.x >= lo && s.bp.x <= lo + 8'd4
                  && s.bp.y >= s.fo.y && s.bp.y <= s.fo.y + 8'd2;
        end
        if (|hit) begin
            s.alive = s.alive & ~hit;
            s.ba    = 1'b0;
        end
    endfunction

    // would a bullet fired now hit anything before it leaves
    function automatic bit will_kill(model_t s);
        model_t t;
        t = s;
        model_frame(t, BTN_FIRE, 1'b0);
        for (int n = 0; n < 32 && t.ba; n++) model_frame(t, BTN_IDLE, 1'b0);
        return t.alive != s.alive;
    endfunction

    task automatic expect_pixels();
        pixel_t want;
        while (exp_q.size() > 0) begin
            want = exp_q.pop_front();
            while (!plot) @(negedge clk);
            check_pixel(pixel, want);
            @(negedge clk);
        end
    endtask

    task automatic play_frame(buttons_t b);
        score_t prev;
        prev = score_of(m);
        @(posedge clk);
        buttons <= b;
        model_frame(m, b, 1'b1);
        @(negedge clk);
        while (!plot) @(negedge clk);
        check_score(score, prev);    // last frame's hit check has settled
        check_flag(game_over, 1'b0, "game_over");
        expect_pixels();
    endtask

    task automatic startup_frame();
        player_shape(m.px, COL_PLAYER);
        enemy_blocks(m, COL_ENEMY);
        if (exp_q.size() != 79) begin
            $display("startup model queued %0d pixels instead of 79", exp_q.size());
            abort_run();
        end
        expect_pixels();
        check_score(score, 3'd0);
        check_flag(game_over, 1'b0, "game_over");
    endtask

    task automatic move_player();
        repeat (25) play_frame(BTN_LEFT);    // 80 down to 8, then held
        repeat (50) play_frame(BTN_RIGHT);   // up to 152
    endtask

    task automatic fly_bullet();
        repeat (8) play_frame(BTN_LEFT);     // x 128 lies between enemy lanes
        play_frame(BTN_FIRE);
        repeat (4) play_frame(BTN_IDLE);
        play_frame(BTN_FIRE);                // ignored, bullet still up
        repeat (24) play_frame(BTN_IDLE);
    endtask

    task automatic march_fleet();
        repeat (50) play_frame(BTN_IDLE);
    endtask

    task automatic destroy_fleet();
        buttons_t    b;
        coord_t      tx;
        logic [31:0] r;
        int          k;
        int          n;
        n = 0;
        while (m.alive != '0) begin
            if (n == MAX_HUNT_FRAMES) begin
                $display("fleet still alive after %0d frames", n);
                abort_run();
            end
            k = 0;
            while (!m.alive[k]) k++;
            tx = coord_t'(30 * k + 22);          // middle of that enemy's sweep
            b  = BTN_IDLE;
            r  = next_random();
            if (!m.ba && will_kill(m)) begin
                b = BTN_FIRE;
            end else if (r[1:0] != 2'd0) begin
                if (m.px + 8'd1 < tx) b = BTN_RIGHT;
                else if (m.px > tx + 8'd1) b = BTN_LEFT;
            end
            play_frame(b);
            n++;
        end
        repeat (2 * FRAME_CYCLES) begin
            @(negedge clk);
            if (plot) begin
                $display("plot went high after the last enemy died");
                abort_run();
            end
        end
        check_score(score, score_of(m));
        check_flag(game_over, 1'b1, "game_over");
    endtask

    initial begin
        buttons = BTN_IDLE;
        m.px    = 8'd80;
        m.ba    = 1'b0;
        m.bp    = '0;
        m.fo    = '{x: 8'd10, y: 8'd10};
        m.fl    = 1'b0;
        m.alive = '1;
        wait (resetn === 1'b1);
        startup_frame();
        move_player();
        fly_bullet();
        march_fleet();
        destroy_fleet();
        $display("All tests passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before all frames were plotted");
        abort_run();
    end

endmodule

// ==== project.f ====
hw/game_pkg.sv
hw/draw_pkg.sv
hw/game_ctrl.sv
hw/sprite_plotter.sv
hw/enemy_fleet.sv
hw/shooter.sv
hw/space_invaders_top.sv
dv/tb_clock.sv
dv/tb_top.sv
